// ==== rtl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // geometry
    localparam int addr_w     = 32;
    localparam int index_w    = 4;
    localparam int word_off_w = 2;
    localparam int byte_off_w = 4;                              // byte within a line
    localparam int tag_w      = addr_w - index_w - byte_off_w;  // 24
    localparam int set_num    = 1 << index_w;
    localparam int word_num   = 1 << word_off_w;
    localparam int line_w     = 128;

    // strobe codes, lane 0
    localparam logic [3:0] sel_byte = 4'b0001;
    localparam logic [3:0] sel_half = 4'b0011;
    localparam logic [3:0] sel_word = 4'b1111;

    // controller state codes
    localparam logic [2:0] st_idle       = 3'd0;
    localparam logic [2:0] st_lookup     = 3'd1;
    localparam logic [2:0] st_writeback  = 3'd2;
    localparam logic [2:0] st_refill     = 3'd3;
    localparam logic [2:0] st_fill_write = 3'd4;

    // one line, seen flat or as words
    typedef union packed {
        logic [line_w-1:0]         flat;
        logic [word_num-1:0][31:0] words;
    } cache_line_u;

endpackage

`default_nettype wire

// ==== rtl/dcache_tag_store.sv ====
`default_nettype none

module dcache_tag_store (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [dcache_pkg::index_w-1:0] i_rd_index,
    input  logic [dcache_pkg::index_w-1:0] i_wr_index,
    input  logic [dcache_pkg::tag_w-1:0]   i_tag,
    input  logic [1:0]                     i_tag_we,
    input  logic                           i_dirty_val,
    input  logic                           i_lru_we,
    input  logic                           i_lru_way,
    output logic                           o_hit,
    output logic                           o_hit_way,
    output logic                           o_victim_way,
    output logic                           o_victim_dirty,
    output logic [dcache_pkg::tag_w-1:0]   o_victim_tag
);
    import dcache_pkg::*;

    logic [tag_w-1:0]        tag_mem [2][set_num];
    logic [1:0][set_num-1:0] valid;
    logic [1:0][set_num-1:0] dirty;
    logic [set_num-1:0]      lru;       // least recently used way per set
    logic [tag_w-1:0]        rd_tag [2];
    logic [1:0]              rd_valid;
    logic [1:0]              hit;

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (i_tag_we[w])
                tag_mem[w][i_wr_index] <= i_tag;
            rd_tag[w] <= tag_mem[w][i_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid    <= '0;
            dirty    <= '0;
            lru      <= '0;
            rd_valid <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (i_tag_we[w]) begin
                    valid[w][i_wr_index] <= 1'b1;
                    dirty[w][i_wr_index] <= i_dirty_val;   // set on store, cleared on clean fill
                end
                rd_valid[w] <= valid[w][i_rd_index];
            end
            if (i_lru_we)
                lru[i_wr_index] <= ~i_lru_way;  // the other way becomes the next victim
        end
    end

    // compare against the registered read
    assign hit[0]    = rd_valid[0] && (rd_tag[0] == i_tag);
    assign hit[1]    = rd_valid[1] && (rd_tag[1] == i_tag);
    assign o_hit     = |hit;
    assign o_hit_way = hit[1];

    // fill an empty way first
    assign o_victim_way   = !rd_valid[0] ? 1'b0 :
                            !rd_valid[1] ? 1'b1 : lru[i_wr_index];
    assign o_victim_tag   = rd_tag[o_victim_way];
    assign o_victim_dirty = rd_valid[o_victim_way] && dirty[o_victim_way][i_wr_index];

    // a fill only ever goes to a way that missed
    a_single_hit : assert property (@(posedge clk) disable iff (!rstn) !(hit[0] && hit[1]));

endmodule

`default_nettype wire

// ==== rtl/dcache_data_store.sv ====
`default_nettype none

module dcache_data_store (
    input  logic                             clk,
    input  logic [dcache_pkg::index_w-1:0]   i_rd_index,
    input  logic [dcache_pkg::index_w-1:0]   i_wr_index,
    input  logic [1:0]                       i_we,
    input  logic                             i_fill,
    input  logic [dcache_pkg::line_w/8-1:0]  i_byte_en,
    input  dcache_pkg::cache_line_u          i_line,
    output dcache_pkg::cache_line_u          o_line0,
    output dcache_pkg::cache_line_u          o_line1
);
    import dcache_pkg::*;

    cache_line_u rd_line [2];

    for (genvar w = 0; w < 2; w++) begin : g_way
        cache_line_u mem [set_num];

        always_ff @(posedge clk) begin
            // whole line on a fill, strobed bytes on a store hit
            for (int b = 0; b < line_w / 8; b++) begin
                if (i_we[w] && (i_fill || i_byte_en[b]))
                    mem[i_wr_index].flat[8*b +: 8] <= i_line.flat[8*b +: 8];
            end
            rd_line[w] <= mem[i_rd_index];
        end
    end

    assign o_line0 = rd_line[0];
    assign o_line1 = rd_line[1];

endmodule

`default_nettype wire

// ==== rtl/dcache_align.sv ====
`default_nettype none

module dcache_align (
    input  logic [31:0]                     i_adr,
    input  logic [31:0]                     i_dat,
    input  logic [3:0]                      i_sel,
    input  logic                            i_signed,
    input  dcache_pkg::cache_line_u         i_line,
    output logic [dcache_pkg::line_w/8-1:0] o_byte_en,
    output dcache_pkg::cache_line_u         o_wr_line,
    output logic [31:0]                     o_load_val,
    output logic                            o_misaligned
);
    import dcache_pkg::*;

    logic [word_off_w-1:0] word_idx;
    logic [1:0]            byte_idx;
    logic [3:0]            lane_sel;
    logic [31:0]           lane_dat;
    logic [31:0]           word_val;
    logic [31:0]           lane_val;

    assign word_idx = i_adr[byte_off_w-1:2];
    assign byte_idx = i_adr[1:0];

    // store side: move lane 0 strobe and data up to the addressed byte
    assign lane_sel  = i_sel << byte_idx;
    assign lane_dat  = i_dat << {byte_idx, 3'b000};
    assign o_byte_en = {{(line_w/8-4){1'b0}}, lane_sel} << {word_idx, 2'b00};

    always_comb begin
        o_wr_line = i_line;     // refill line with the store on top
        for (int b = 0; b < 4; b++) begin
            if (lane_sel[b])
                o_wr_line.words[word_idx][8*b +: 8] = lane_dat[8*b +: 8];
        end
    end

    // load side
    assign word_val = i_line.words[word_idx];
    assign lane_val = word_val >> {byte_idx, 3'b000};

    always_comb begin
        case (i_sel)
            sel_byte: o_load_val = {{24{i_signed & lane_val[7]}}, lane_val[7:0]};
            sel_half: o_load_val = {{16{i_signed & lane_val[15]}}, lane_val[15:0]};
            default:  o_load_val = word_val;
        endcase
    end

    always_comb begin
        case (i_sel)
            sel_half: o_misaligned = i_adr[0];
            sel_word: o_misaligned = |i_adr[1:0];
            default:  o_misaligned = 1'b0;     // bytes are always aligned
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/dcache_ctrl.sv ====
`default_nettype none

module dcache_ctrl (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           i_cyc,
    input  logic                           i_stb,
    input  logic                           i_we,
    input  logic                           i_signed,
    input  logic [31:0]                    i_adr,
    input  logic [31:0]                    i_dat,
    input  logic [3:0]                     i_sel,
    output logic                           o_ack,
    output logic                           o_err,
    output logic [31:0]                    o_dat,
    output logic                           o_mem_cyc,
    output logic                           o_mem_stb,
    output logic                           o_mem_we,
    output logic [31:0]                    o_mem_adr,
    output dcache_pkg::cache_line_u        o_mem_dat,
    input  logic                           i_mem_ack,
    input  dcache_pkg::cache_line_u        i_mem_dat,
    output logic [dcache_pkg::index_w-1:0] o_index,
    output logic [dcache_pkg::tag_w-1:0]   o_lookup_tag,
    input  logic                           i_hit,
    input  logic                           i_hit_way,
    input  logic                           i_victim_way,
    input  logic                           i_victim_dirty,
    input  logic [dcache_pkg::tag_w-1:0]   i_victim_tag,
    output logic [1:0]                     o_tag_we,
    output logic                           o_dirty_val,
    output logic                           o_lru_we,
    output logic                           o_lru_way,
    output logic [1:0]                     o_data_we,
    output logic                           o_fill,
    input  dcache_pkg::cache_line_u        i_rd_line,
    output logic [31:0]                    o_req_adr,
    output logic [31:0]                    o_req_dat,
    output logic [3:0]                     o_req_sel,
    output logic                           o_req_signed,
    input  logic [31:0]                    i_load_val,
    input  logic                           i_misaligned
);
    import dcache_pkg::*;

    logic [2:0]         state;
    logic               accept;
    logic               req_we;
    logic [index_w-1:0] req_index;
    logic               fill_way;
    logic [tag_w-1:0]   wb_tag;
    cache_line_u        line_buf;   // victim line and later the refill line

    // the ack/err cycle still shows the old stb and is not a new request
    assign accept    = i_cyc && i_stb && !o_ack && !o_err;
    assign req_index = o_req_adr[byte_off_w +: index_w];

    assign o_index      = (state == st_idle) ? i_adr[byte_off_w +: index_w] : req_index;
    assign o_lookup_tag = o_req_adr[addr_w-1 -: tag_w];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_idle;
            o_ack <= 1'b0;
            o_err <= 1'b0;
        end else begin
            o_ack <= 1'b0;
            o_err <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept)
                        state <= st_lookup;
                end
                st_lookup: begin
                    if (i_misaligned) begin
                        o_err <= 1'b1;
                        state <= st_idle;
                    end else if (i_hit) begin
                        o_ack <= 1'b1;
                        state <= st_idle;
                    end else if (i_victim_dirty) begin
                        state <= st_writeback;
                    end else begin
                        state <= st_refill;
                    end
                end
                st_writeback: begin
                    if (i_mem_ack)
                        state <= st_refill;
                end
                st_refill: begin
                    if (i_mem_ack)
                        state <= st_fill_write;
                end
                st_fill_write: begin
                    o_ack <= 1'b1;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && accept) begin
            o_req_adr    <= i_adr;
            o_req_dat    <= i_dat;
            o_req_sel    <= i_sel;
            o_req_signed <= i_signed;
            req_we       <= i_we;
        end
        if (state == st_lookup) begin
            line_buf <= i_rd_line;
            fill_way <= i_victim_way;
            wb_tag   <= i_victim_tag;
        end
        if (state == st_refill && i_mem_ack) begin
            line_buf <= i_mem_dat;
            // a load puts the fetched bytes back over themselves in the fill
            if (!req_we)
                o_req_dat <= i_mem_dat.words[o_req_adr[byte_off_w-1:2]]
                             >> {o_req_adr[1:0], 3'b000};
        end
        if ((state == st_lookup && i_hit) || state == st_fill_write)
            o_dat <= i_load_val;
    end

    always_comb begin
        o_tag_we    = '0;
        o_data_we   = '0;
        o_dirty_val = 1'b0;
        o_lru_we    = 1'b0;
        o_lru_way   = 1'b0;
        o_fill      = 1'b0;
        case (state)
            st_lookup: begin
                if (i_hit && !i_misaligned) begin
                    o_lru_we  = 1'b1;
                    o_lru_way = i_hit_way;
                    if (req_we) begin
                        o_data_we[i_hit_way] = 1'b1;
                        o_tag_we[i_hit_way]  = 1'b1;   // same tag rewritten as dirty
                        o_dirty_val          = 1'b1;
                    end
                end
            end
            st_fill_write: begin
                o_fill              = 1'b1;
                o_data_we[fill_way] = 1'b1;
                o_tag_we[fill_way]  = 1'b1;
                o_dirty_val         = req_we;
                o_lru_we            = 1'b1;
                o_lru_way           = fill_way;
            end
            default: ;
        endcase
    end

    assign o_mem_cyc = (state == st_writeback) || (state == st_refill);
    assign o_mem_stb = o_mem_cyc;
    assign o_mem_we  = (state == st_writeback);
    assign o_mem_adr = {(state == st_writeback) ? wb_tag : o_lookup_tag, req_index,
                        {byte_off_w{1'b0}}};
    // in lookup the array line is passed on so the align unit reads the hit data
    assign o_mem_dat = (state == st_lookup) ? i_rd_line : line_buf;

    // a response is a single-cycle pulse
    a_resp_pulse : assert property (@(posedge clk) disable iff (!rstn)
        (o_ack || o_err) |=> !(o_ack || o_err));
    // each memory transfer holds still until the slave acks
    a_mem_hold   : assert property (@(posedge clk) disable iff (!rstn)
        o_mem_stb && !i_mem_ack |=> o_mem_stb && $stable(o_mem_adr) && $stable(o_mem_we)
                                    && $stable(o_mem_dat));

endmodule

`default_nettype wire

// ==== rtl/dcache_top.sv ====
`default_nettype none

module dcache_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    i_cyc,
    input  logic                    i_stb,
    input  logic                    i_we,
    input  logic                    i_signed,
    input  logic [31:0]             i_adr,
    input  logic [31:0]             i_dat,
    input  logic [3:0]              i_sel,
    output logic                    o_ack,
    output logic                    o_err,
    output logic [31:0]             o_dat,
    output logic                    o_mem_cyc,
    output logic                    o_mem_stb,
    output logic                    o_mem_we,
    output logic [31:0]             o_mem_adr,
    output dcache_pkg::cache_line_u o_mem_dat,
    input  logic                    i_mem_ack,
    input  dcache_pkg::cache_line_u i_mem_dat
);
    import dcache_pkg::*;

    logic [index_w-1:0]  lookup_index;
    logic [tag_w-1:0]    lookup_tag;
    logic                hit;
    logic                hit_way;
    logic                victim_way;
    logic                victim_dirty;
    logic [tag_w-1:0]    victim_tag;
    logic [1:0]          tag_we;
    logic                dirty_val;
    logic                lru_we;
    logic                lru_way;
    logic [1:0]          data_we;
    logic                fill;
    cache_line_u         line0;
    cache_line_u         line1;
    cache_line_u         rd_line;
    cache_line_u         wr_line;
    logic [31:0]         req_adr;
    logic [31:0]         req_dat;
    logic [3:0]          req_sel;
    logic                req_signed;
    logic [31:0]         load_val;
    logic                misaligned;
    logic [line_w/8-1:0] byte_en;

    // hit way on a hit, victim way on a miss
    assign rd_line = (hit ? hit_way : victim_way) ? line1 : line0;

    dcache_ctrl u_ctrl (
        .*,
        .o_index        (lookup_index),
        .o_lookup_tag   (lookup_tag),
        .i_hit          (hit),
        .i_hit_way      (hit_way),
        .i_victim_way   (victim_way),
        .i_victim_dirty (victim_dirty),
        .i_victim_tag   (victim_tag),
        .o_tag_we       (tag_we),
        .o_dirty_val    (dirty_val),
        .o_lru_we       (lru_we),
        .o_lru_way      (lru_way),
        .o_data_we      (data_we),
        .o_fill         (fill),
        .i_rd_line      (rd_line),
        .o_req_adr      (req_adr),
        .o_req_dat      (req_dat),
        .o_req_sel      (req_sel),
        .o_req_signed   (req_signed),
        .i_load_val     (load_val),
        .i_misaligned   (misaligned)
    );

    dcache_tag_store u_tag_store (
        .clk            (clk),
        .rstn           (rstn),
        .i_rd_index     (lookup_index),
        .i_wr_index     (req_adr[byte_off_w +: index_w]),
        .i_tag          (lookup_tag),
        .i_tag_we       (tag_we),
        .i_dirty_val    (dirty_val),
        .i_lru_we       (lru_we),
        .i_lru_way      (lru_way),
        .o_hit          (hit),
        .o_hit_way      (hit_way),
        .o_victim_way   (victim_way),
        .o_victim_dirty (victim_dirty),
        .o_victim_tag   (victim_tag)
    );

    dcache_data_store u_data_store (
        .clk        (clk),
        .i_rd_index (lookup_index),
        .i_wr_index (req_adr[byte_off_w +: index_w]),
        .i_we       (data_we),
        .i_fill     (fill),
        .i_byte_en  (byte_en),
        .i_line     (wr_line),
        .o_line0    (line0),
        .o_line1    (line1)
    );

    dcache_align u_align (
        .i_adr        (req_adr),
        .i_dat        (req_dat),
        .i_sel        (req_sel),
        .i_signed     (req_signed),
        .i_line       (o_mem_dat),      // hit line in lookup, refill line in fill
        .o_byte_en    (byte_en),
        .o_wr_line    (wr_line),
        .o_load_val   (load_val),
        .o_misaligned (misaligned)
    );

endmodule

`default_nettype wire

// ==== sim/dcache_checker.sv ====
`default_nettype none

module dcache_checker (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_cyc,
    input  logic        i_stb,
    input  logic        i_we,
    input  logic [31:0] i_adr,
    input  logic        i_ack,
    input  logic        i_err,
    input  logic [31:0] i_rd_dat,
    input  logic        i_mem_cyc,
    input  logic [31:0] i_exp_dat,
    input  logic        i_exp_err,
    output int          o_checks,
    output int          o_errors
);
    timeunit 1ns;
    timeprecision 1ps;

    logic        busy;
    logic        req_we;
    logic [31:0] req_adr;
    logic [31:0] req_exp_dat;
    logic        req_exp_err;
    logic        mem_seen;      // memory port used during this request
    int          edges;

    initial begin
        busy     = 1'b0;
        mem_seen = 1'b0;
        edges    = 0;
        o_checks = 0;
        o_errors = 0;
    end

    task automatic compare_response();
        o_checks++;
        if (i_err !== req_exp_err) begin
            $display("ERR %0t o_err expected %0b actual %0b at adr %08h",
                     $time, req_exp_err, i_err, req_adr);
            o_errors++;
        end else if (!req_we && !req_exp_err && i_rd_dat !== req_exp_dat) begin
            $display("ERR %0t o_dat expected %08h actual %08h at adr %08h",
                     $time, req_exp_dat, i_rd_dat, req_adr);
            o_errors++;
        end
        if (i_err && mem_seen) begin
            $display("%0t: the error response for %08h came with memory traffic",
                     $time, req_adr);
            o_errors++;
        end
        // hits and misaligned requests answer on the second edge
        if (!mem_seen && edges != 2) begin
            $display("%0t: request at %08h stayed in the cache but took %0d edges, not 2",
                     $time, req_adr, edges);
            o_errors++;
        end
    endtask

    // sampled on the rising edge, inputs move on the falling one
    always @(posedge clk) begin
        if (!rstn) begin
            busy = 1'b0;
        end else if (busy) begin
            if (i_mem_cyc)
                mem_seen = 1'b1;
            if (i_ack || i_err) begin
                compare_response();
                busy = 1'b0;
            end else begin
                edges++;
            end
        end else if (i_ack || i_err) begin
            $display("%0t: a response came while no request was open", $time);
            o_errors++;
        end else if (i_cyc && i_stb) begin
            busy        = 1'b1;
            edges       = 1;
            mem_seen    = 1'b0;
            req_we      = i_we;
            req_adr     = i_adr;
            req_exp_dat = i_exp_dat;
            req_exp_err = i_exp_err;
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_dcache.sv ====
`default_nettype none

module tb_dcache;
    timeunit 1ns;
    timeprecision 1ps;

    import dcache_pkg::*;

    logic        clk = 1'b0;
    logic        rstn;
    logic        i_cyc;
    logic        i_stb;
    logic        i_we;
    logic        i_signed;
    logic [31:0] i_adr;
    logic [31:0] i_dat;
    logic [3:0]  i_sel;
    logic        o_ack;
    logic        o_err;
    logic [31:0] o_dat;
    logic        o_mem_cyc;
    logic        o_mem_stb;
    logic        o_mem_we;
    logic [31:0] o_mem_adr;
    cache_line_u o_mem_dat;
    logic        i_mem_ack;
    cache_line_u i_mem_dat;

    logic [31:0] exp_dat;
    logic        exp_err;
    int          chk_checks;
    int          chk_errors;
    int          tb_errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          n_vec = 0;
    bit          aborted = 1'b0;
    integer      seed = 32'h8e2f1a66;

    // one entry per request line of the stimulus file
    logic        v_we[$];
    logic [31:0] v_adr[$];
    logic [3:0]  v_sel[$];
    logic [31:0] v_dat[$];
    logic        v_signed[$];
    logic [31:0] v_exp_dat[$];
    logic        v_exp_err[$];

    logic [31:0] mem_words [16384];     // lowest 64 KiB of the address space

    always #10 clk = ~clk;

    dcache_top u_dut (.*);

    dcache_checker u_checker (
        .clk       (clk),
        .rstn      (rstn),
        .i_cyc     (i_cyc),
        .i_stb     (i_stb),
        .i_we      (i_we),
        .i_adr     (i_adr),
        .i_ack     (o_ack),
        .i_err     (o_err),
        .i_rd_dat  (o_dat),
        .i_mem_cyc (o_mem_cyc),
        .i_exp_dat (exp_dat),
        .i_exp_err (exp_err),
        .o_checks  (chk_checks),
        .o_errors  (chk_errors)
    );

    task automatic load_vectors(output bit ok);
        int          fd;
        int          code;
        string       text;
        logic        f_we;
        logic [31:0] f_adr;
        logic [3:0]  f_sel;
        logic [31:0] f_dat;
        logic        f_signed;
        logic [31:0] f_exp_dat;
        logic        f_exp_err;
        ok = 1'b0;
        fd = $fopen("sim/dcache_stimulus.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fgets(text, fd);
                if (code > 0 && text.getc(0) != "#") begin
                    code = $sscanf(text, "%h %h %h %h %h %h %h", f_we, f_adr, f_sel,
                                   f_dat, f_signed, f_exp_dat, f_exp_err);
                    if (code == 7) begin
                        v_we.push_back(f_we);
                        v_adr.push_back(f_adr);
                        v_sel.push_back(f_sel);
                        v_dat.push_back(f_dat);
                        v_signed.push_back(f_signed);
                        v_exp_dat.push_back(f_exp_dat);
                        v_exp_err.push_back(f_exp_err);
                    end
                end
            end
            $fclose(fd);
            ok = (v_adr.size() > 0);
        end
    endtask

    // one Wishbone classic request held until ack or err
    task automatic run_request(input int k);
        @(negedge clk);
        i_we     = v_we[k];
        i_adr    = v_adr[k];
        i_sel    = v_sel[k];
        i_dat    = v_we[k] ? v_dat[k] : $random(seed);     // noise on the bus for a read
        i_signed = v_signed[k];
        exp_dat  = v_exp_dat[k];
        exp_err  = v_exp_err[k];
        i_cyc    = 1'b1;
        i_stb    = 1'b1;
        @(negedge clk);
        while (!(o_ack || o_err))
            @(negedge clk);
        i_cyc = 1'b0;
        i_stb = 1'b0;
    endtask

    task automatic end_run();
        int total;
        if (!aborted && chk_checks != n_vec) begin
            $display("only %0d of %0d requests were answered", chk_checks, n_vec);
            tb_errors++;
        end
        total = chk_errors + tb_errors;
        $display("vectors %0d  checks %0d  checker errors %0d  testbench errors %0d",
                 n_vec, chk_checks, chk_errors, tb_errors);
        if (total == 0 && !aborted)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    endtask

    // a memory transfer is one whole line
    task automatic serve_transfer();
        int base;
        if (o_mem_adr[31:16] != 16'h0000) begin
            $display("memory access at %08h lies outside the modelled range", o_mem_adr);
            tb_errors++;
        end
        base = int'(o_mem_adr[15:2]);
        for (int k = 0; k < word_num; k++) begin
            if (o_mem_we)
                mem_words[base + k] = o_mem_dat.words[k];
            else
                i_mem_dat.words[k] = mem_words[base + k];
        end
    endtask

    // line memory answering after 0 to 3 extra cycles
    initial begin
        int mem_wait;
        for (int a = 0; a < 16384; a++)
            mem_words[a] = (a << 2) ^ 32'h5a5a0000;
        i_mem_ack = 1'b0;
        i_mem_dat = '0;
        forever begin
            @(negedge clk);
            if (rstn && o_mem_cyc && o_mem_stb) begin
                mem_wait = $random(seed) & 3;
                repeat (mem_wait) @(negedge clk);
                serve_transfer();
                i_mem_ack = 1'b1;
                @(negedge clk);
                i_mem_ack = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout, the run did not end within %0d cycles", cycle_limit);
            aborted = 1'b1;
            end_run();
        end
    end

    initial begin
        bit ok;
        rstn     = 1'b0;
        i_cyc    = 1'b0;
        i_stb    = 1'b0;
        i_we     = 1'b0;
        i_signed = 1'b0;
        i_adr    = '0;
        i_dat    = '0;
        i_sel    = '0;
        exp_dat  = '0;
        exp_err  = 1'b0;
        load_vectors(ok);
        n_vec       = v_adr.size();
        cycle_limit = n_vec * 60 + 200;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        if (!ok) begin
            $display("no request could be read from the stimulus file");
            aborted = 1'b1;
            end_run();
        end else begin
            for (int k = 0; k < n_vec; k++)
                run_request(k);
            repeat (3) @(negedge clk);
            end_run();
        end
    end

endmodule

`default_nettype wire

// ==== sim/dcache_stimulus.txt ====
# we adr sel dat signed exp_dat exp_err, all hex, one request per line
# sel is the lane 0 code (1 byte, 3 half, f word), a read carries its expected value as dat
0 00000100 f 5a5a0100 0 5a5a0100 0
0 00000100 f 5a5a0100 0 5a5a0100 0
1 00000101 1 000000ab 0 00000000 0
1 00000102 3 0000cdef 0 00000000 0
0 00000100 f cdefab00 0 cdefab00 0
0 00000101 1 000000ab 1 ffffffab 0
0 00000101 1 000000ab 0 000000ab 0
0 00000102 3 0000cdef 1 ffffcdef 0
0 00000102 3 0000cdef 0 0000cdef 0
0 00000107 1 0000005a 1 0000005a 0
0 00000103 3 00000000 0 00000000 1
1 00000102 f deadbeef 0 00000000 1
0 00000100 f cdefab00 0 cdefab00 0
0 00000200 f 5a5a0200 0 5a5a0200 0
1 00000208 f 11223344 0 00000000 0
0 00000100 f cdefab00 0 cdefab00 0
0 00000300 f 5a5a0300 0 5a5a0300 0
0 00000400 f 5a5a0400 0 5a5a0400 0
0 00000208 f 11223344 0 11223344 0
0 00000100 f cdefab00 0 cdefab00 0
1 00000052 3 00007e81 0 00000000 0
0 00000050 f 7e810050 0 7e810050 0
0 00000052 3 00007e81 1 00007e81 0
1 00000064 f a5a5c3c3 0 00000000 0
0 00000067 1 000000a5 1 ffffffa5 0
0 00000066 3 0000a5a5 0 0000a5a5 0

// ==== verilog.f ====
rtl/dcache_pkg.sv
rtl/dcache_tag_store.sv
rtl/dcache_data_store.sv
rtl/dcache_align.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
sim/dcache_checker.sv
sim/tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - rtl/dcache_pkg.sv
  - rtl/dcache_tag_store.sv
  - rtl/dcache_data_store.sv
  - rtl/dcache_align.sv
  - rtl/dcache_ctrl.sv
  - rtl/dcache_top.sv
  - target: simulation
    files:
      - sim/dcache_checker.sv
      - sim/tb_dcache.sv
